// ==== dac_drv.sv ====
module dac_drv (
    input  logic                          clk491520,
    input  logic                          rst_ip,
    input  logic                          rd_valid_i,
    input  logic [dmix_pkg::SAMPLE_W-1:0] rd_data_i,
    output logic                          pop_o,
    output logic                          bck_o,
    output logic                          lrck_o,
    output logic                          data_o
);

    logic [dmix_pkg::FRAME_CW-1:0]  cnt;
    logic                           bck_fall;
    logic                           pop_q;
    logic [dmix_pkg::SLOT_BITS-1:0] shreg;
    logic                           data_q;

    // Free-running frame counter, wraps at FRAME_CYCLES
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // bck low in the first half of each bit period
    assign bck_o  = cnt[dmix_pkg::BCK_BIT];
    // lrck low in the left slot
    assign lrck_o = cnt[dmix_pkg::FRAME_CW-1];

    // Last cycle before bck goes low
    assign bck_fall = &cnt[dmix_pkg::BCK_BIT:0];

    // Pop is high two cycles before each slot begins
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            pop_q <= 1'b0;
        end else begin
            pop_q <= (cnt == dmix_pkg::POP_R_CNT) || (cnt == dmix_pkg::POP_L_CNT);
        end
    end

    assign pop_o = pop_q;

    // Shift on bck falling edges
    // The load edge is also a falling edge, so the previous slot's last bit
    // goes out for one bck and gives the I2S delay
    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            shreg  <= '0;
            data_q <= 1'b0;
        end else if (bck_fall) begin
            data_q <= shreg[dmix_pkg::SLOT_BITS-1];
            if (rd_valid_i) begin
                shreg <= {rd_data_i, {dmix_pkg::PAD_BITS{1'b0}}};
            end else begin
                shreg <= {shreg[dmix_pkg::SLOT_BITS-2:0], 1'b0};
            end
        end
    end

    assign data_o = data_q;

    // Answer from the ring buffer lands one cycle later
    rd_follows_pop: assert property (
        @(posedge clk491520) disable iff (rst_ip) pop_o |=> rd_valid_i
    ) else $error("rd_valid_i missing after pop_o");

    no_stray_rd: assert property (
        @(posedge clk491520) disable iff (rst_ip) rd_valid_i |-> $past(pop_o)
    ) else $error("rd_valid_i without pop_o");

    // Load must meet a falling edge or the slot alignment is lost
    load_on_fall: assert property (
        @(posedge clk491520) disable iff (rst_ip) rd_valid_i |-> bck_fall
    ) else $error("rd_valid_i off the bck falling edge");

endmodule

// ==== dmix_pkg.sv ====
package dmix_pkg;

    // Audio sample width
    localparam int SAMPLE_W = 24;

    // Ring buffer geometry, depth is a power of two
    localparam int RB_DEPTH = 16;
    localparam int RB_AW    = 4;

    // I2S timing in clk491520 cycles
    localparam int BCK_HALF     = 4;
    localparam int SLOT_BITS    = 32;
    localparam int FRAME_CYCLES = 2 * SLOT_BITS * 2 * BCK_HALF;

    // Derived frame counter values
    localparam int SLOT_CYCLES = FRAME_CYCLES / 2;
    localparam int FRAME_CW    = $clog2(FRAME_CYCLES);
    localparam int BCK_BIT     = $clog2(BCK_HALF);

    // Counter values one cycle ahead of the pop instants
    localparam logic [FRAME_CW-1:0] POP_R_CNT = FRAME_CW'(SLOT_CYCLES - 3);
    localparam logic [FRAME_CW-1:0] POP_L_CNT = FRAME_CW'(FRAME_CYCLES - 3);

    // Zero bits after the sample in each slot
    localparam int PAD_BITS = SLOT_BITS - SAMPLE_W;

endpackage

// ==== dmix_top.sv ====
module dmix_top (
    input  logic                          clk491520,
    input  logic                          rst_ip,
    input  logic [dmix_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                          left_i,
    input  logic                          req_i,
    output logic                          ack_o,
    output logic                          dac_bck_o,
    output logic                          dac_lrck_o,
    output logic                          dac_data_o,
    output logic                          overrun_o,
    output logic                          underrun_o
);

    logic                          frame_we;
    logic [dmix_pkg::SAMPLE_W-1:0] frame_left;
    logic [dmix_pkg::SAMPLE_W-1:0] frame_right;
    logic                          pop;
    logic                          rd_valid;
    logic [dmix_pkg::SAMPLE_W-1:0] rd_data;

    sample_ingest u_ingest (
        .clk491520     (clk491520),
        .rst_ip        (rst_ip),
        .sample_i      (sample_i),
        .left_i        (left_i),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .frame_we_o    (frame_we),
        .frame_left_o  (frame_left),
        .frame_right_o (frame_right)
    );

    ringbuf u_rb (
        .clk491520     (clk491520),
        .rst_ip        (rst_ip),
        .frame_we_i    (frame_we),
        .frame_left_i  (frame_left),
        .frame_right_i (frame_right),
        .pop_i         (pop),
        .rd_valid_o    (rd_valid),
        .rd_data_o     (rd_data),
        .overrun_o     (overrun_o),
        .underrun_o    (underrun_o)
    );

    dac_drv u_dac (
        .clk491520  (clk491520),
        .rst_ip     (rst_ip),
        .rd_valid_i (rd_valid),
        .rd_data_i  (rd_data),
        .pop_o      (pop),
        .bck_o      (dac_bck_o),
        .lrck_o     (dac_lrck_o),
        .data_o     (dac_data_o)
    );

endmodule

// ==== dmix_vectors.txt ====
# F <left hex> <right hex> sends one frame, L <hex> and R <hex> send a lone sample
# G <cycles, decimal> idles the source
G 1100
F 100001 200001
F 100002 200002
L 3DEAD1
L 100003
R 200003
R 3BAD02
F 100004 200004
R 3BAD03
G 3000
F 110001 220001
F 110002 220002
F 110003 220003
F 110004 220004
F 110005 220005
F 110006 220006
F 110007 220007
F 110008 220008
F 110009 220009
F 11000A 22000A
F 11000B 22000B
F 11000C 22000C
F 11000D 22000D
F 11000E 22000E
F 11000F 22000F
F 110010 220010
F 110011 220011
F 110012 220012
F 110013 220013
F 110014 220014
G 12000

// ==== project.f ====
dmix_pkg.sv
sample_ingest.sv
ringbuf.sv
dac_drv.sv
dmix_top.sv
tb_dmix.sv

// ==== ringbuf.sv ====
module ringbuf (
    input  logic                          clk491520,
    input  logic                          rst_ip,
    input  logic                          frame_we_i,
    input  logic [dmix_pkg::SAMPLE_W-1:0] frame_left_i,
    input  logic [dmix_pkg::SAMPLE_W-1:0] frame_right_i,
    input  logic                          pop_i,
    output logic                          rd_valid_o,
    output logic [dmix_pkg::SAMPLE_W-1:0] rd_data_o,
    output logic                          overrun_o,
    output logic                          underrun_o
);

    logic [dmix_pkg::SAMPLE_W-1:0] mem_l [dmix_pkg::RB_DEPTH];
    logic [dmix_pkg::SAMPLE_W-1:0] mem_r [dmix_pkg::RB_DEPTH];
    logic [dmix_pkg::RB_AW-1:0]    wr_ptr;
    logic [dmix_pkg::RB_AW-1:0]    rd_ptr;
    logic [dmix_pkg::RB_AW:0]      count;
    logic                          full;
    logic                          empty;
    logic                          do_write;
    logic                          do_free;
    logic                          next_is_right;
    logic                          lat_v;
    logic [dmix_pkg::SAMPLE_W-1:0] lat_right;

    // Depth is a power of two, so the top count bit means full
    assign full     = count[dmix_pkg::RB_AW];
    assign empty    = (count == '0);
    assign do_write = frame_we_i & ~full;
    assign do_free  = pop_i & next_is_right & lat_v;

    always_ff @(posedge clk491520) begin
        if (do_write) begin
            mem_l[wr_ptr] <= frame_left_i;
            mem_r[wr_ptr] <= frame_right_i;
        end
    end

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            // Counter starts mid left slot, so the right pop comes first
            next_is_right <= 1'b1;
            lat_v         <= 1'b0;
            rd_valid_o    <= 1'b0;
            overrun_o     <= 1'b0;
            underrun_o    <= 1'b0;
        end else begin
            rd_valid_o <= pop_i;
            overrun_o  <= frame_we_i & full;
            underrun_o <= pop_i & ~next_is_right & empty;
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_free) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_free})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (pop_i) begin
                next_is_right <= ~next_is_right;
                if (!next_is_right) begin
                    lat_v <= ~empty;
                end
            end
        end
    end

    // Read data path, muted frames read as zero
    always_ff @(posedge clk491520) begin
        if (pop_i && !next_is_right) begin
            lat_right <= empty ? '0 : mem_r[rd_ptr];
            rd_data_o <= empty ? '0 : mem_l[rd_ptr];
        end else if (pop_i) begin
            rd_data_o <= lat_v ? lat_right : '0;
        end
    end

    count_bound: assert property (
        @(posedge clk491520) disable iff (rst_ip) count <= dmix_pkg::RB_DEPTH
    ) else $error("ring buffer count above depth");

    pop_spacing: assert property (
        @(posedge clk491520) disable iff (rst_ip) pop_i |=> !pop_i
    ) else $error("pops on consecutive cycles");

endmodule

// ==== sample_ingest.sv ====
module sample_ingest (
    input  logic                          clk491520,
    input  logic                          rst_ip,
    input  logic [dmix_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                          left_i,
    input  logic                          req_i,
    output logic                          ack_o,
    output logic                          frame_we_o,
    output logic [dmix_pkg::SAMPLE_W-1:0] frame_left_o,
    output logic [dmix_pkg::SAMPLE_W-1:0] frame_right_o
);

    logic                          ack_q;
    logic                          take;
    logic                          pair_done;
    logic                          held_v;
    logic [dmix_pkg::SAMPLE_W-1:0] held_left;
    logic                          we_q;
    logic [dmix_pkg::SAMPLE_W-1:0] left_q;
    logic [dmix_pkg::SAMPLE_W-1:0] right_q;

    // Sample accepted on the edge where ack goes high
    assign take      = req_i & ~ack_q;
    assign pair_done = take & ~left_i & held_v;

    always_ff @(posedge clk491520) begin
        if (rst_ip) begin
            ack_q  <= 1'b0;
            held_v <= 1'b0;
            we_q   <= 1'b0;
        end else begin
            ack_q <= req_i;
            we_q  <= pair_done;
            // Any right sample empties the holding slot, orphan or not
            if (take) begin
                held_v <= left_i;
            end
        end
    end

    always_ff @(posedge clk491520) begin
        // Newer left replaces the held one
        if (take && left_i) begin
            held_left <= sample_i;
        end
        if (pair_done) begin
            left_q  <= held_left;
            right_q <= sample_i;
        end
    end

    assign ack_o         = ack_q;
    assign frame_we_o    = we_q;
    assign frame_left_o  = left_q;
    assign frame_right_o = right_q;

    // Source side of the four-phase protocol
    req_waits_ack_low: assert property (
        @(posedge clk491520) disable iff (rst_ip)
        $rose(req_i) |-> !ack_o
    ) else $error("req_i rose while ack_o was high");

endmodule

// ==== tb_dmix.sv ====
module tb_dmix;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS       = 10;
    localparam int HS_TIMEOUT   = 20;
    localparam int SYNC_TIMEOUT = 2 * dmix_pkg::FRAME_CYCLES;

    logic                          clk491520 = 1'b0;
    logic                          rst_ip;
    logic [dmix_pkg::SAMPLE_W-1:0] sample_i;
    logic                          left_i;
    logic                          req_i;
    logic                          ack_o;
    logic                          dac_bck_o;
    logic                          dac_lrck_o;
    logic                          dac_data_o;
    logic                          overrun_o;
    logic                          underrun_o;

    // Source side pairing model
    logic [dmix_pkg::SAMPLE_W-1:0] exp_l [$];
    logic [dmix_pkg::SAMPLE_W-1:0] exp_r [$];
    logic [dmix_pkg::SAMPLE_W-1:0] held;
    logic                          held_v = 1'b0;
    integer                        formed = 0;

    // I2S receiver state
    logic                          slot_lr = 1'b0;
    logic                          running = 1'b0;
    integer                        bit_idx = 0;
    integer                        last_bck = 0;
    logic [dmix_pkg::SAMPLE_W-1:0] shift;
    logic [dmix_pkg::SAMPLE_W-1:0] got_left;
    logic                          mute_pending = 1'b0;
    logic                          frame_mute = 1'b0;
    integer                        frames_seen = 0;
    integer                        muted_frames = 0;
    integer                        delivered = 0;
    integer                        last_muted = 0;
    integer                        first_muted = 0;
    integer                        underrun_cnt = 0;
    integer                        overrun_cnt = 0;

    dmix_top u_dut (
        .clk491520  (clk491520),
        .rst_ip     (rst_ip),
        .sample_i   (sample_i),
        .left_i     (left_i),
        .req_i      (req_i),
        .ack_o      (ack_o),
        .dac_bck_o  (dac_bck_o),
        .dac_lrck_o (dac_lrck_o),
        .dac_data_o (dac_data_o),
        .overrun_o  (overrun_o),
        .underrun_o (underrun_o)
    );

    always #(CLK_NS / 2) clk491520 = ~clk491520;

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sample(input string name, input logic [dmix_pkg::SAMPLE_W-1:0] got,
                                input logic [dmix_pkg::SAMPLE_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input integer got, input integer exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_fields(input integer got, input integer want);
        if (got != want) begin
            $display("Malformed line in dmix_vectors.txt");
            stop_run();
        end
    endtask

    // One four-phase transfer, called on a falling edge
    task automatic send_sample(input logic [dmix_pkg::SAMPLE_W-1:0] s, input logic is_left);
        integer n;
        sample_i = s;
        left_i   = is_left;
        req_i    = 1'b1;
        n        = 0;
        do begin
            @(negedge clk491520);
            n++;
        end while (!ack_o && n < HS_TIMEOUT);
        if (!ack_o) begin
            $display("Timed out waiting for ack_o to rise");
            stop_run();
        end
        check_count("ack_o rise latency", n, 1);
        req_i = 1'b0;
        n     = 0;
        do begin
            @(negedge clk491520);
            n++;
        end while (ack_o && n < HS_TIMEOUT);
        if (ack_o) begin
            $display("Timed out waiting for ack_o to fall");
            stop_run();
        end
        check_count("ack_o fall latency", n, 1);
        if (is_left) begin
            held   = s;
            held_v = 1'b1;
        end else if (held_v) begin
            held_v = 1'b0;
            formed++;
            exp_l.push_back(held);
            exp_r.push_back(s);
        end
    endtask

    task automatic take_frame(input logic [dmix_pkg::SAMPLE_W-1:0] l,
                              input logic [dmix_pkg::SAMPLE_W-1:0] r);
        integer k;
        if (l == '0 && r == '0) begin
            muted_frames++;
            check_count("underrun_o before muted frame", frame_mute, 1);
            last_muted = 1;
        end else begin
            check_count("underrun_o before live frame", frame_mute, 0);
            if (exp_l.size() == 0) begin
                $display("A live frame came out with no expected frame pending");
                stop_run();
            end
            // Skip frames that an overrun dropped
            k = 0;
            while (k < exp_l.size() && exp_l[k] !== l) begin
                k++;
            end
            if (k == exp_l.size()) begin
                check_sample("dac left sample", l, exp_l[0]);
            end
            repeat (k) begin
                exp_l.delete(0);
                exp_r.delete(0);
            end
            exp_l.delete(0);
            check_sample("dac right sample", r, exp_r.pop_front());
            delivered++;
            last_muted = 0;
        end
        if (frames_seen == 0) begin
            first_muted = last_muted;
        end
        frames_seen++;
    endtask

    always @(negedge clk491520) begin
        if (!rst_ip) begin
            if (underrun_o) begin
                underrun_cnt++;
                mute_pending = 1'b1;
            end
            if (overrun_o) begin
                overrun_cnt++;
            end
        end
    end

    // I2S receiver, first bit of each slot is the delay bit
    always @(posedge dac_bck_o) begin
        if (!rst_ip) begin
            if (running) begin
                check_count("dac_bck_o period in ns", $time - last_bck,
                            2 * dmix_pkg::BCK_HALF * CLK_NS);
            end
            last_bck = $time;
            if (dac_lrck_o !== slot_lr) begin
                if (running) begin
                    check_count("dac_bck_o periods per dac_lrck_o slot", bit_idx + 1,
                                dmix_pkg::SLOT_BITS);
                end
                slot_lr = dac_lrck_o;
                bit_idx = 0;
                if (!dac_lrck_o) begin
                    running      = 1'b1;
                    frame_mute   = mute_pending;
                    mute_pending = 1'b0;
                end
            end else begin
                bit_idx++;
            end
            if (running && bit_idx >= 1 && bit_idx <= dmix_pkg::SAMPLE_W) begin
                shift = {shift[dmix_pkg::SAMPLE_W-2:0], dac_data_o};
                if (bit_idx == dmix_pkg::SAMPLE_W) begin
                    if (!slot_lr) begin
                        got_left = shift;
                    end else begin
                        take_frame(got_left, shift);
                    end
                end
            end
        end
    end

    initial begin
        integer                        fd;
        integer                        r;
        integer                        n;
        integer                        seen;
        logic [7:0]                    op;
        logic [dmix_pkg::SAMPLE_W-1:0] a;
        logic [dmix_pkg::SAMPLE_W-1:0] b;
        logic [8*128-1:0]              rest;
        rst_ip   = 1'b1;
        sample_i = '0;
        left_i   = 1'b0;
        req_i    = 1'b0;
        repeat (5) @(posedge clk491520);
        @(negedge clk491520);
        rst_ip = 1'b0;
        fd = $fopen("dmix_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open dmix_vectors.txt");
            stop_run();
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            case (op)
                "#": r = $fgets(rest, fd);
                "F": begin
                    r = $fscanf(fd, "%h %h", a, b);
                    check_fields(r, 2);
                    send_sample(a, 1'b1);
                    send_sample(b, 1'b0);
                end
                "L": begin
                    r = $fscanf(fd, "%h", a);
                    check_fields(r, 1);
                    send_sample(a, 1'b1);
                end
                "R": begin
                    r = $fscanf(fd, "%h", a);
                    check_fields(r, 1);
                    send_sample(a, 1'b0);
                end
                "G": begin
                    r = $fscanf(fd, "%d", n);
                    check_fields(r, 1);
                    repeat (n) @(negedge clk491520);
                end
                default: begin
                    $display("Unknown command in dmix_vectors.txt");
                    stop_run();
                end
            endcase
        end
        $fclose(fd);
        // Line up with the end of an output frame
        seen = frames_seen;
        n    = 0;
        do begin
            @(negedge clk491520);
            n++;
        end while (frames_seen == seen && n < SYNC_TIMEOUT);
        if (frames_seen == seen) begin
            $display("Timed out waiting for a complete output frame");
            stop_run();
        end
        check_count("first frame after reset muted", first_muted, 1);
        check_count("output muted after drain", last_muted, 1);
        check_count("muted frames vs underrun_o pulses", muted_frames, underrun_cnt);
        check_count("delivered plus overruns vs sent", delivered + overrun_cnt, formed);
        if (overrun_cnt == 0) begin
            $display("The burst did not overflow the ring buffer");
            stop_run();
        end
        $display("No errors");
        $finish;
    end

endmodule
